/* hdl/snn_conv_cfg.svh */
// ========================================
// Geometry and widths of the conv layer
// Stride is fixed at 1, only one input channel
// Output map equals input map (pad 1, kernel 3)
// ========================================
`ifndef SNN_CONV_CFG_SVH
`define SNN_CONV_CFG_SVH

// ========================================
// Map geometry
// ========================================
`define SNN_IN_H            8
`define SNN_IN_W            8
`define SNN_OUT_CH          2
`define SNN_KERNEL          3
`define SNN_PAD             1

// Total neurons, channel x row x col
`define SNN_NEURONS         (`SNN_OUT_CH * `SNN_IN_H * `SNN_IN_W)

// ========================================
// Data widths
// ========================================
`define SNN_WORD_W          32
`define SNN_WEIGHT_W        8
`define SNN_VMEM_W          16
`define SNN_WADDR_W         16

// 1.0 in Q8.8
`define SNN_THRESH_DEFAULT  256

`endif

/* hdl/snn_conv_pkg.sv */
// ========================================
// Shared types and helpers of the conv layer
// Index functions truncate to the target width
// ========================================
`include "snn_conv_cfg.svh"

package snn_conv_pkg;

    // Stream word {channel, row, column, timestamp}
    typedef logic [`SNN_WORD_W-1:0] spike_word_t;
    typedef logic signed [`SNN_WEIGHT_W-1:0] weight_t;
    // Potential, also used for the threshold
    typedef logic signed [`SNN_VMEM_W-1:0] vmem_t;
    typedef logic [$clog2(`SNN_NEURONS)-1:0] neuron_addr_t;
    typedef logic [`SNN_WADDR_W-1:0] weight_addr_t;

    // Flat neuron index, channel-major
    function automatic neuron_addr_t neuron_index(input logic [7:0] ch,
                                                  input logic [7:0] row,
                                                  input logic [7:0] col);
        return neuron_addr_t'(ch * (`SNN_IN_H * `SNN_IN_W) + row * `SNN_IN_W + col);
    endfunction

    // Weight layout [out_ch][k_row][k_col]
    function automatic weight_addr_t weight_index(input logic [7:0] oc,
                                                  input logic [7:0] kr,
                                                  input logic [7:0] kc);
        return weight_addr_t'(oc * (`SNN_KERNEL * `SNN_KERNEL) + kr * `SNN_KERNEL + kc);
    endfunction

    // Potential plus weight, clamped to the signed range
    function automatic vmem_t sat_add(input vmem_t acc, input weight_t w);
        logic signed [`SNN_VMEM_W:0] sum;
        sum = {acc[`SNN_VMEM_W-1], acc} +
              {{(`SNN_VMEM_W + 1 - `SNN_WEIGHT_W){w[`SNN_WEIGHT_W-1]}}, w};
        // Overflow when the two top bits disagree
        if (sum[`SNN_VMEM_W] != sum[`SNN_VMEM_W-1]) begin
            return sum[`SNN_VMEM_W] ? {1'b1, {(`SNN_VMEM_W-1){1'b0}}}
                                    : {1'b0, {(`SNN_VMEM_W-1){1'b1}}};
        end
        return sum[`SNN_VMEM_W-1:0];
    endfunction

endpackage

/* hdl/conv_sequencer.sv */
// ========================================
// Spike intake and kernel-tap walk
// Channel field of the input word is ignored
// One weight fetch in flight at a time
// All taps are fetched, off-map ones are dropped
// ========================================
`timescale 1ns/1ns
`include "snn_conv_cfg.svh"

module conv_sequencer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       s_spike_valid,
    input  snn_conv_pkg::spike_word_t  s_spike_data,
    output logic                       s_spike_ready,
    output logic                       weight_rd_en,
    output snn_conv_pkg::weight_addr_t weight_addr,
    input  snn_conv_pkg::weight_t      weight_data,
    input  logic                       weight_valid,
    output logic                       acc_en,
    output snn_conv_pkg::neuron_addr_t acc_addr,
    output snn_conv_pkg::weight_t      acc_weight,
    output logic                       scan_start,
    output logic [7:0]                 scan_timestamp,
    input  logic                       scan_done
);
    import snn_conv_pkg::*;

    // Counter widths, at least one bit each
    localparam int OC_W = (`SNN_OUT_CH > 1) ? $clog2(`SNN_OUT_CH) : 1;
    localparam int K_W  = $clog2(`SNN_KERNEL);
    localparam logic [OC_W-1:0] OC_LAST = OC_W'(`SNN_OUT_CH - 1);
    localparam logic [K_W-1:0]  K_LAST  = K_W'(`SNN_KERNEL - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_WAIT,
        S_SCAN
    } state_t;

    state_t          state;
    logic [7:0]      in_row;
    logic [7:0]      in_col;
    logic [7:0]      in_ts;
    logic [OC_W-1:0] out_ch;
    logic [K_W-1:0]  k_row;
    logic [K_W-1:0]  k_col;
    logic signed [9:0] tgt_row;
    logic signed [9:0] tgt_col;
    logic            in_map;
    logic            last_tap;

    // ========================================
    // Target neuron of the current tap
    // ========================================
    always_comb begin
        // out = in + pad - k, stride 1
        tgt_row = $signed(10'(in_row)) + 10'(`SNN_PAD) - $signed(10'(k_row));
        tgt_col = $signed(10'(in_col)) + 10'(`SNN_PAD) - $signed(10'(k_col));
        in_map  = (tgt_row >= 0) && (tgt_row < `SNN_IN_H) &&
                  (tgt_col >= 0) && (tgt_col < `SNN_IN_W);
        last_tap = (out_ch == OC_LAST) && (k_row == K_LAST) && (k_col == K_LAST);
    end

    // Fetch strobe lasts exactly the FETCH cycle
    assign weight_rd_en = (state == S_FETCH);
    assign weight_addr  = weight_index(8'(out_ch), 8'(k_row), 8'(k_col));

    // Accumulate in the cycle the weight shows up
    assign acc_en     = (state == S_WAIT) && weight_valid && in_map;
    assign acc_addr   = neuron_index(8'(out_ch), tgt_row[7:0], tgt_col[7:0]);
    assign acc_weight = weight_data;

    assign scan_timestamp = in_ts;

    // ========================================
    // Control FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            s_spike_ready <= 1'b1;
            scan_start    <= 1'b0;
            out_ch        <= '0;
            k_row         <= '0;
            k_col         <= '0;
        end else begin
            scan_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (s_spike_valid && s_spike_ready) begin
                        s_spike_ready <= 1'b0;
                        out_ch        <= '0;
                        k_row         <= '0;
                        k_col         <= '0;
                        state         <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    if (weight_valid) begin
                        // Column fastest, then row, then channel
                        if (k_col == K_LAST) begin
                            k_col <= '0;
                            if (k_row == K_LAST) begin
                                k_row  <= '0;
                                out_ch <= (out_ch == OC_LAST) ? '0 : out_ch + 1'b1;
                            end else begin
                                k_row <= k_row + 1'b1;
                            end
                        end else begin
                            k_col <= k_col + 1'b1;
                        end
                        if (last_tap) begin
                            scan_start <= 1'b1;
                            state      <= S_SCAN;
                        end else begin
                            state <= S_FETCH;
                        end
                    end
                end
                S_SCAN: begin
                    // Intake reopens only once the scan has finished
                    if (scan_done) begin
                        s_spike_ready <= 1'b1;
                        state         <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Spike payload, taken on acceptance
    always_ff @(posedge clk) begin
        if (state == S_IDLE && s_spike_valid && s_spike_ready) begin
            in_row <= s_spike_data[23:16];
            in_col <= s_spike_data[15:8];
            in_ts  <= s_spike_data[7:0];
        end
    end

endmodule

/* hdl/vmem_array.sv */
// ========================================
// Membrane potential store, one word per neuron
// Accumulate and scan ports are never used together
// Accumulate wins if both are driven
// ========================================
`timescale 1ns/1ns
`include "snn_conv_cfg.svh"

module vmem_array (
    input  logic                       clk,
    input  logic                       rst_n,
    // Accumulate port
    input  logic                       acc_en,
    input  snn_conv_pkg::neuron_addr_t acc_addr,
    input  snn_conv_pkg::weight_t      acc_weight,
    // Scan port
    input  snn_conv_pkg::neuron_addr_t scan_addr,
    output snn_conv_pkg::vmem_t        scan_vmem,
    input  logic                       scan_clear
);
    import snn_conv_pkg::*;

    // ========================================
    // Storage
    // ========================================
    // Flops, so the whole map starts at zero
    vmem_t vmem [`SNN_NEURONS];

    // Current value at the accumulate address
    vmem_t acc_old;

    assign acc_old = vmem[acc_addr];

    // Combinational read for the scanner
    assign scan_vmem = vmem[scan_addr];

    // ========================================
    // Write port
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SNN_NEURONS; i++) begin
                vmem[i] <= '0;
            end
        end else if (acc_en) begin
            // Read-modify-write in one cycle
            vmem[acc_addr] <= sat_add(acc_old, acc_weight);
        end else if (scan_clear) begin
            // Neuron fired, back to rest
            vmem[scan_addr] <= '0;
        end
    end

endmodule

/* hdl/fire_scanner.sv */
// ========================================
// Threshold register and fire scan
// Scan order is channel, row, column
// Stalls on a firing neuron until ready
// Threshold should only change while idle
// ========================================
`timescale 1ns/1ns
`include "snn_conv_cfg.svh"

module fire_scanner (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       scan_start,
    input  logic [7:0]                 scan_timestamp,
    output snn_conv_pkg::neuron_addr_t scan_addr,
    input  snn_conv_pkg::vmem_t        scan_vmem,
    output logic                       scan_clear,
    output logic                       scan_done,
    input  snn_conv_pkg::vmem_t        config_threshold,
    input  logic                       config_valid,
    output logic                       m_spike_valid,
    output snn_conv_pkg::spike_word_t  m_spike_data,
    input  logic                       m_spike_ready
);
    import snn_conv_pkg::*;

    localparam int           MAP       = `SNN_IN_H * `SNN_IN_W;
    localparam neuron_addr_t LAST_ADDR = neuron_addr_t'(`SNN_NEURONS - 1);

    logic       running;
    logic [7:0] scan_ts;
    vmem_t      threshold;
    logic       fire;
    logic       step;

    // ========================================
    // Threshold
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            threshold <= vmem_t'(`SNN_THRESH_DEFAULT);
        end else if (config_valid) begin
            threshold <= config_threshold;
        end
    end

    // ========================================
    // Per-neuron decision
    // ========================================
    always_comb begin
        // Signed compare, at or above fires
        fire = running && (scan_vmem >= threshold);
        // Non-firing neurons take one cycle
        step = running && (!fire || m_spike_ready);
        scan_clear = fire && m_spike_ready;
        scan_done  = step && (scan_addr == LAST_ADDR);
    end

    // Word held stable while the address is stalled
    assign m_spike_valid = fire;
    assign m_spike_data  = {8'(scan_addr / MAP),
                            8'((scan_addr % MAP) / `SNN_IN_W),
                            8'(scan_addr % `SNN_IN_W),
                            scan_ts};

    // ========================================
    // Scan address walk
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running   <= 1'b0;
            scan_addr <= '0;
        end else if (!running) begin
            if (scan_start) begin
                running   <= 1'b1;
                scan_addr <= '0;
            end
        end else if (step) begin
            if (scan_addr == LAST_ADDR) begin
                running   <= 1'b0;
                scan_addr <= '0;
            end else begin
                scan_addr <= scan_addr + 1'b1;
            end
        end
    end

    // Timestamp of the spike that started this scan
    always_ff @(posedge clk) begin
        if (scan_start && !running) begin
            scan_ts <= scan_timestamp;
        end
    end

endmodule

/* hdl/snn_conv_top.sv */
// ========================================
// Event-driven conv layer, top level
// Weight memory sits outside, one read at a time
// ========================================
`timescale 1ns/1ns

module snn_conv_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // Input spike stream
    input  logic                       s_spike_valid,
    input  snn_conv_pkg::spike_word_t  s_spike_data,
    output logic                       s_spike_ready,
    // Weight memory
    output logic                       weight_rd_en,
    output snn_conv_pkg::weight_addr_t weight_addr,
    input  snn_conv_pkg::weight_t      weight_data,
    input  logic                       weight_valid,
    // Threshold load
    input  snn_conv_pkg::vmem_t        config_threshold,
    input  logic                       config_valid,
    // Output spike stream
    output logic                       m_spike_valid,
    output snn_conv_pkg::spike_word_t  m_spike_data,
    input  logic                       m_spike_ready
);
    import snn_conv_pkg::*;

    // Sequencer to store
    logic         acc_en;
    neuron_addr_t acc_addr;
    weight_t      acc_weight;
    // Sequencer to scanner
    logic         scan_start;
    logic [7:0]   scan_timestamp;
    logic         scan_done;
    // Scanner to store
    neuron_addr_t scan_addr;
    vmem_t        scan_vmem;
    logic         scan_clear;

    conv_sequencer conv_sequencer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .s_spike_valid  (s_spike_valid),
        .s_spike_data   (s_spike_data),
        .s_spike_ready  (s_spike_ready),
        .weight_rd_en   (weight_rd_en),
        .weight_addr    (weight_addr),
        .weight_data    (weight_data),
        .weight_valid   (weight_valid),
        .acc_en         (acc_en),
        .acc_addr       (acc_addr),
        .acc_weight     (acc_weight),
        .scan_start     (scan_start),
        .scan_timestamp (scan_timestamp),
        .scan_done      (scan_done)
    );

    vmem_array vmem_array_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc_en     (acc_en),
        .acc_addr   (acc_addr),
        .acc_weight (acc_weight),
        .scan_addr  (scan_addr),
        .scan_vmem  (scan_vmem),
        .scan_clear (scan_clear)
    );

    fire_scanner fire_scanner_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .scan_start       (scan_start),
        .scan_timestamp   (scan_timestamp),
        .scan_addr        (scan_addr),
        .scan_vmem        (scan_vmem),
        .scan_clear       (scan_clear),
        .scan_done        (scan_done),
        .config_threshold (config_threshold),
        .config_valid     (config_valid),
        .m_spike_valid    (m_spike_valid),
        .m_spike_data     (m_spike_data),
        .m_spike_ready    (m_spike_ready)
    );

endmodule

/* verif/snn_conv_properties.sv */
// ========================================
// Protocol assertions, bound into the top level
// One weight fetch in flight at a time
// Output word held stable under back-pressure
// violations counts every failed assertion
// ========================================
`timescale 1ns/1ns

module snn_conv_properties (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      m_spike_valid,
    input logic                      m_spike_ready,
    input snn_conv_pkg::spike_word_t m_spike_data,
    input logic                      weight_rd_en,
    input logic                      weight_valid
);
    int   violations = 0;
    // Set by a fetch, cleared when its weight returns
    logic fetch_pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pending <= 1'b0;
        end else if (weight_rd_en) begin
            fetch_pending <= 1'b1;
        end else if (weight_valid) begin
            fetch_pending <= 1'b0;
        end
    end

    // Stalled output keeps its word
    output_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_spike_valid && !m_spike_ready |=> m_spike_valid && $stable(m_spike_data))
        else begin
            violations++;
            $error("output spike word changed while stalled");
        end

    // Fetch strobe is a single-cycle pulse
    fetch_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        weight_rd_en |=> !weight_rd_en)
        else begin
            violations++;
            $error("weight_rd_en held longer than one cycle");
        end

    // No new fetch before the previous weight returned
    fetch_single: assert property (@(posedge clk) disable iff (!rst_n)
        weight_rd_en |-> !fetch_pending)
        else begin
            violations++;
            $error("second weight fetch issued before weight_valid");
        end

endmodule

bind snn_conv_top snn_conv_properties snn_conv_properties_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .m_spike_valid (m_spike_valid),
    .m_spike_ready (m_spike_ready),
    .m_spike_data  (m_spike_data),
    .weight_rd_en  (weight_rd_en),
    .weight_valid  (weight_valid)
);

/* verif/snn_conv_tb.sv */
// ========================================
// Testbench of the spiking conv layer
// Weight memory answers each read after 2 cycles
// Reference model tracks all potentials in ints
// Inputs change 1 ns after the rising edge
// Outputs are sampled on the rising edge
// ========================================
`timescale 1ns/1ns
`include "snn_conv_cfg.svh"

module snn_conv_tb;
    import snn_conv_pkg::*;

    localparam int MAP          = `SNN_IN_H * `SNN_IN_W;
    localparam int KK           = `SNN_KERNEL * `SNN_KERNEL;
    localparam int N_TAPS       = `SNN_OUT_CH * KK;
    // Spikes outside the saturation burst
    localparam int FIXED_SPIKES = 30;
    // Fetch walk plus scan plus back-pressure margin
    localparam int SPIKE_CYCLES = 400;

    logic         clk;
    logic         rst_n;
    logic         s_spike_valid;
    spike_word_t  s_spike_data;
    logic         s_spike_ready;
    logic         weight_rd_en;
    weight_addr_t weight_addr;
    weight_t      weight_data;
    logic         weight_valid;
    vmem_t        config_threshold;
    logic         config_valid;
    logic         m_spike_valid;
    spike_word_t  m_spike_data;
    logic         m_spike_ready;

    logic [31:0]  lfsr = 32'h7de4;
    weight_t      wmem [N_TAPS];
    weight_addr_t rd_addr;
    int           model_v [`SNN_NEURONS];
    int           model_thresh;
    spike_word_t  exp_q [$];
    int           fetch_count = 0;
    int           value_errors = 0;
    int           other_errors = 0;
    int           cycles = 0;
    int           cycle_limit = 20000;
    bit           random_ready = 1'b0;

    snn_conv_top snn_conv_top_i (.*);

    // ========================================
    // Clock, timeout, weight memory
    // ========================================
    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // One read at a time, data and valid two cycles later
    initial begin
        weight_data  = '0;
        weight_valid = 1'b0;
        forever begin
            @(posedge clk);
            if (weight_rd_en) begin
                rd_addr = weight_addr;
                // Taps walked in weight layout order, so address = tap number
                check_weight_addr(rd_addr, weight_addr_t'(fetch_count % N_TAPS));
                fetch_count++;
                @(posedge clk);
                #1;
                weight_data  = (rd_addr < N_TAPS) ? wmem[rd_addr] : '0;
                weight_valid = 1'b1;
                @(posedge clk);
                #1;
                weight_valid = 1'b0;
            end
        end
    end

    // ========================================
    // Random bits, Fibonacci LFSR x^32+x^22+x^2+x+1
    // ========================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // ========================================
    // Reference model
    // ========================================
    function automatic int clamp16(input int v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    // Apply all taps, then scan and queue the expected words
    task automatic model_spike(input int row, input int col, input logic [7:0] ts);
        int      tr;
        int      tc;
        int      n;
        weight_t w;
        for (int oc = 0; oc < `SNN_OUT_CH; oc++) begin
            for (int kr = 0; kr < `SNN_KERNEL; kr++) begin
                for (int kc = 0; kc < `SNN_KERNEL; kc++) begin
                    tr = row + `SNN_PAD - kr;
                    tc = col + `SNN_PAD - kc;
                    w  = wmem[oc * KK + kr * `SNN_KERNEL + kc];
                    if (tr >= 0 && tr < `SNN_IN_H && tc >= 0 && tc < `SNN_IN_W) begin
                        n = oc * MAP + tr * `SNN_IN_W + tc;
                        model_v[n] = clamp16(model_v[n] + int'(w));
                    end
                end
            end
        end
        // Scan in channel, row, column order
        for (int ch = 0; ch < `SNN_OUT_CH; ch++) begin
            for (int r = 0; r < `SNN_IN_H; r++) begin
                for (int c = 0; c < `SNN_IN_W; c++) begin
                    n = ch * MAP + r * `SNN_IN_W + c;
                    if (model_v[n] >= model_thresh) begin
                        exp_q.push_back({8'(ch), 8'(r), 8'(c), ts});
                        model_v[n] = 0;
                    end
                end
            end
        end
    endtask

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_spike(input spike_word_t got, input spike_word_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s output spike %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_vmem_count(input int got, input int exp, input string what);
        if (got != exp) begin
            value_errors++;
            $display("Fail at %0t: %s made %0d weight fetches, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_weight_addr(input weight_addr_t got, input weight_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t: weight fetch address %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ========================================
    // Drivers
    // ========================================
    // Waits for an idle layer, then one config strobe
    task automatic load_threshold(input vmem_t t);
        bit idle;
        idle = 1'b0;
        while (!idle) begin
            @(posedge clk);
            idle = s_spike_ready;
            #1;
        end
        config_threshold = t;
        config_valid     = 1'b1;
        @(posedge clk);
        #1;
        config_valid = 1'b0;
        model_thresh = int'(t);
    endtask

    // Sends one spike and checks every output until ready returns
    task automatic send_spike(input int row, input int col, input logic [7:0] ts,
                              input string tag);
        int          fetch_start;
        bit          accepted;
        bit          done;
        logic [31:0] rbits;
        model_spike(row, col, ts);
        fetch_start   = fetch_count;
        s_spike_valid = 1'b1;
        s_spike_data  = {8'h00, 8'(row), 8'(col), ts};
        accepted      = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = s_spike_ready;
            #1;
        end
        s_spike_valid = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (m_spike_valid && m_spike_ready) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("Unexpected output spike %h at %0t during %s",
                             m_spike_data, $time, tag);
                end else begin
                    check_spike(m_spike_data, exp_q.pop_front(), tag);
                end
            end
            done = s_spike_ready;
            #1;
            rand_bits(1, rbits);
            m_spike_ready = random_ready ? rbits[0] : 1'b1;
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%0d expected output spikes never appeared during %s", exp_q.size(), tag);
            exp_q.delete();
        end
        check_vmem_count(fetch_count - fetch_start, N_TAPS, tag);
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic reset_values();
        @(posedge clk);
        check_flag(s_spike_ready, 1'b1, "s_spike_ready after reset");
        check_flag(m_spike_valid, 1'b0, "m_spike_valid after reset");
        check_flag(weight_rd_en, 1'b0, "weight_rd_en after reset");
        #1;
    endtask

    // Threshold 1, so only positive taps fire
    task automatic center_spike();
        load_threshold(16'sd1);
        send_spike(4, 4, 8'h11, "center spike");
    endtask

    task automatic corner_spike();
        send_spike(0, 0, 8'h22, "corner spike");
    endtask

    task automatic threshold_accumulate();
        load_threshold(vmem_t'(`SNN_THRESH_DEFAULT));
        for (int i = 0; i < 8; i++) begin
            send_spike(2, 5, 8'(8'h40 + i), "accumulation");
        end
    endtask

    // Random pixels, then a burst that drives the most negative tap to its floor
    task automatic random_backpressure(input int sat_reps);
        logic [31:0] r;
        logic [31:0] c;
        logic [31:0] ts;
        random_ready = 1'b1;
        for (int i = 0; i < 20; i++) begin
            rand_bits(3, r);
            rand_bits(3, c);
            rand_bits(8, ts);
            send_spike(int'(r), int'(c), ts[7:0], "random spike");
        end
        for (int i = 0; i < sat_reps; i++) begin
            send_spike(4, 4, 8'(i), "saturation burst");
        end
        random_ready = 1'b0;
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        logic [31:0] bits;
        weight_t     wmin;
        int          sat_reps;
        int          total;
        rst_n            = 1'b0;
        s_spike_valid    = 1'b0;
        s_spike_data     = '0;
        config_threshold = '0;
        config_valid     = 1'b0;
        m_spike_ready    = 1'b1;
        for (int i = 0; i < N_TAPS; i++) begin
            rand_bits(8, bits);
            wmem[i] = weight_t'(bits[7:0]);
        end
        for (int n = 0; n < `SNN_NEURONS; n++) begin
            model_v[n] = 0;
        end
        model_thresh = `SNN_THRESH_DEFAULT;
        // Spikes needed to push one neuron from below threshold past -32768
        wmin = '0;
        for (int i = 0; i < N_TAPS; i++) begin
            if (wmem[i] < wmin) wmin = wmem[i];
        end
        sat_reps    = (wmin < 0) ? ((32768 + `SNN_THRESH_DEFAULT) / -int'(wmin) + 2) : 0;
        cycle_limit = (FIXED_SPIKES + sat_reps) * SPIKE_CYCLES + 200;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        reset_values();
        center_spike();
        corner_spike();
        threshold_accumulate();
        random_backpressure(sat_reps);

        total = value_errors + other_errors + snn_conv_top_i.snn_conv_properties_i.violations;
        $display("Errors: %0d value, %0d protocol, %0d assertion", value_errors, other_errors,
                 snn_conv_top_i.snn_conv_properties_i.violations);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+hdl
hdl/snn_conv_pkg.sv
hdl/conv_sequencer.sv
hdl/vmem_array.sv
hdl/fire_scanner.sv
hdl/snn_conv_top.sv
verif/snn_conv_properties.sv
verif/snn_conv_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := snn_conv_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := All checks passed
SOURCES   := $(shell grep -v '^+' $(FILELIST)) hdl/snn_conv_cfg.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
